// ==== rtl/jsp_byte_fifo.sv ====
// Byte FIFO with strobe and valid/ready sides and saturated fill and space counts
`timescale 1ns/100ps
`default_nettype none

module jsp_byte_fifo
  import jsp_pkg::*;
#(
  parameter int unsigned fifo_depth = 8  // Entries, 2 to 15
) (
  input  logic      tck_i,
  input  logic      rst_i,
  input  logic      push_i,       // Strobe side write
  input  jsp_byte_t push_data_i,
  input  logic      pop_i,        // Strobe side read
  input  logic      out_ready_i,  // Host side read
  input  logic      in_valid_i,   // Host side write
  input  jsp_byte_t in_data_i,
  output jsp_byte_t head_o,       // Oldest entry
  output logic      out_valid_o,
  output logic      in_ready_o,
  output jsp_cnt_t  fill_o,
  output jsp_cnt_t  space_o
);

  localparam int unsigned PTR_W = $clog2(fifo_depth);
  localparam int unsigned CNT_W = $clog2(fifo_depth + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(fifo_depth - 1);

  jsp_byte_t        mem [fifo_depth];  // Storage, no reset
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;           // Entries held
  logic             wr_en;
  logic             rd_en;
  jsp_byte_t        wr_data;

  // Clamp a count to the 4 bit status field
  function automatic jsp_cnt_t sat_cnt(input int unsigned val);
    return (val > 32'(CNT_MAX)) ? CNT_MAX : jsp_cnt_t'(val);
  endfunction

  assign out_valid_o = (count_q != '0);
  assign in_ready_o  = (count_q != CNT_W'(fifo_depth));

  // Only one side of each direction is wired in the top level
  assign wr_en   = push_i | (in_valid_i & in_ready_o);
  assign rd_en   = pop_i | (out_valid_o & out_ready_i);
  assign wr_data = push_i ? push_data_i : in_data_i;

  assign head_o  = mem[rd_ptr_q];
  assign fill_o  = sat_cnt(32'(count_q));
  assign space_o = sat_cnt(32'(fifo_depth) - 32'(count_q));

  always_ff @(posedge tck_i) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= wr_data;
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;  // Wrap at depth
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/jsp_in_ctrl.sv ====
// Input control FSM with write bit counter, input shift register, space and user counters
`timescale 1ns/100ps
`default_nettype none

module jsp_in_ctrl
  import jsp_pkg::*;
#(
  parameter bit start_bit_en = 1'b1  // Wait for a 1 start bit before the header
) (
  input  logic      tck_i,
  input  logic      rst_i,
  input  logic      module_select_i,
  input  logic      capture_dr_i,
  input  logic      shift_dr_i,
  input  logic      update_dr_i,
  input  logic      tdi_i,
  input  jsp_cnt_t  space_i,      // Receive FIFO space
  output logic      push_o,       // Push strobe into the receive FIFO
  output jsp_byte_t push_data_o
);

  typedef enum logic [1:0] {
    WR_IDLE,  // Between frames
    WR_WAIT,  // Looking for the start bit
    WR_HDR,   // Header byte, U in the high nibble
    WR_XFER   // Data bytes
  } wr_state_t;

  wr_state_t  state_q;
  wr_state_t  state_d;
  logic [2:0] bit_cnt_q;    // Bits taken of the current byte
  jsp_byte_t  shift_q;      // Input shift register, LSB first
  jsp_cnt_t   space_q;      // Space left for this frame
  jsp_cnt_t   user_q;       // Bytes still announced by the host
  logic       frame_start;
  logic       bit_en;       // Shift cycle that takes a bit
  logic       byte_done;    // Eighth bit of a byte on tdi_i
  jsp_byte_t  byte_in;      // Byte including the current bit

  assign frame_start = module_select_i & capture_dr_i;
  assign bit_en      = shift_dr_i & ((state_q == WR_HDR) | (state_q == WR_XFER));
  assign byte_done   = bit_en & (bit_cnt_q == LAST_BIT_IDX);
  assign byte_in     = {tdi_i, shift_q[BITS_PER_BYTE-1:1]};

  // Push only while both space and user count remain
  assign push_o      = byte_done & (state_q == WR_XFER) & (space_q != '0) & (user_q != '0);
  assign push_data_o = byte_in;

  ////////////////////////////////////////////////////////////////////////////
  // Next state

  always_comb begin
    state_d = state_q;
    case (state_q)
      WR_IDLE: begin
        if (frame_start) begin
          state_d = start_bit_en ? WR_WAIT : WR_HDR;
        end
      end
      WR_WAIT: begin
        if (update_dr_i) begin
          state_d = WR_IDLE;
        end else if (shift_dr_i && tdi_i) begin
          state_d = WR_HDR;  // Start bit seen, not data
        end
      end
      WR_HDR: begin
        if (update_dr_i) begin
          state_d = WR_IDLE;
        end else if (byte_done) begin
          state_d = WR_XFER;
        end
      end
      WR_XFER: begin
        if (update_dr_i) begin
          state_d = WR_IDLE;
        end
      end
      default: state_d = WR_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // State and counters

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q   <= WR_IDLE;
      bit_cnt_q <= '0;
      space_q   <= '0;
      user_q    <= '0;
    end else begin
      state_q <= state_d;
      if ((state_q == WR_IDLE) && frame_start) begin
        bit_cnt_q <= '0;
        space_q   <= space_i;  // Sampled once per frame
      end else if (bit_en) begin
        bit_cnt_q <= byte_done ? '0 : bit_cnt_q + 1'b1;
      end
      if ((state_q == WR_HDR) && byte_done) begin
        user_q <= byte_in[7:4];  // Low nibble reserved
      end else if (push_o) begin
        user_q <= user_q - 1'b1;
      end
      if (push_o) begin
        space_q <= space_q - 1'b1;
      end
    end
  end

  // Shift register, payload only
  always_ff @(posedge tck_i) begin
    if (bit_en) begin
      shift_q <= byte_in;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/jsp_out_ctrl.sv ====
// Output control FSM with read bit counter, remaining byte counter and TDO shift register
`timescale 1ns/100ps
`default_nettype none

module jsp_out_ctrl
  import jsp_pkg::*;
(
  input  logic      tck_i,
  input  logic      rst_i,
  input  logic      module_select_i,
  input  logic      capture_dr_i,
  input  logic      shift_dr_i,
  input  logic      update_dr_i,
  input  jsp_byte_t tx_head_i,   // Transmit FIFO head byte
  input  jsp_cnt_t  tx_fill_i,   // Transmit FIFO fill
  input  jsp_cnt_t  rx_space_i,  // Receive FIFO space
  output logic      tdo_o,
  output logic      pop_o        // Pop strobe for the transmit FIFO
);

  typedef enum logic [1:0] {
    RD_IDLE,    // Between frames
    RD_STATUS,  // Status byte on TDO
    RD_ACK,     // First bit of a byte, pop happens here
    RD_XFER     // Rest of a data byte
  } rd_state_t;

  rd_state_t  state_q;
  rd_state_t  state_d;
  logic [2:0] bit_cnt_q;     // Bits sent of the current byte
  jsp_cnt_t   remain_q;      // Transmit bytes still owed this frame
  jsp_byte_t  tdo_shift_q;   // Parallel load shift register
  logic       load_status;   // Capture cycle of a selected frame
  logic       bit_en;        // Shift cycle inside a frame
  logic       byte_done;     // Last bit of a byte on TDO

  assign load_status = (state_q == RD_IDLE) & module_select_i & capture_dr_i;
  assign bit_en      = shift_dr_i & (state_q != RD_IDLE);
  assign byte_done   = bit_en & (bit_cnt_q == LAST_BIT_IDX);

  assign tdo_o = tdo_shift_q[0];  // LSB first
  assign pop_o = (state_q == RD_ACK) & shift_dr_i & (remain_q != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Next state

  always_comb begin
    state_d = state_q;
    case (state_q)
      RD_IDLE: begin
        if (load_status) begin
          state_d = RD_STATUS;
        end
      end
      RD_STATUS, RD_XFER: begin
        if (update_dr_i) begin
          state_d = RD_IDLE;
        end else if (byte_done) begin
          state_d = RD_ACK;
        end
      end
      RD_ACK: begin
        if (update_dr_i) begin
          state_d = RD_IDLE;
        end else if (shift_dr_i) begin
          state_d = RD_XFER;  // Pause holds us here
        end
      end
      default: state_d = RD_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // State, counters and TDO register

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q     <= RD_IDLE;
      bit_cnt_q   <= '0;
      remain_q    <= '0;
      tdo_shift_q <= '0;
    end else begin
      state_q <= state_d;

      // Bit counter
      if (load_status) begin
        bit_cnt_q <= '0;
      end else if (bit_en) begin
        bit_cnt_q <= byte_done ? '0 : bit_cnt_q + 1'b1;
      end

      // Remaining bytes, fill sampled at capture
      if (load_status) begin
        remain_q <= tx_fill_i;
      end else if (pop_o) begin
        remain_q <= remain_q - 1'b1;
      end

      // Status byte, then head bytes, then zeros
      if (load_status) begin
        tdo_shift_q <= {tx_fill_i, rx_space_i};
      end else if (byte_done) begin
        tdo_shift_q <= (remain_q != '0) ? tx_head_i : '0;
      end else if (bit_en) begin
        tdo_shift_q <= {1'b0, tdo_shift_q[BITS_PER_BYTE-1:1]};
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/jsp_pkg.sv ====
// Byte and count types plus frame constants shared by the JTAG serial port
`default_nettype none

package jsp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Frame constants

  localparam int unsigned BITS_PER_BYTE = 8;  // Bits in one shifted byte

  // Index of the final bit of a byte, sized for the 3 bit counters
  localparam logic [2:0] LAST_BIT_IDX = 3'(BITS_PER_BYTE - 1);

  ////////////////////////////////////////////////////////////////////////////
  // Types

  typedef logic [BITS_PER_BYTE-1:0] jsp_byte_t;  // One data byte
  typedef logic [3:0] jsp_cnt_t;                 // FIFO byte count, status nibble

  localparam jsp_cnt_t CNT_MAX = '1;  // Counts saturate here

endpackage

`default_nettype wire

// ==== rtl/jsp_top.sv ====
// JTAG serial port top level with both controllers and the receive and transmit FIFOs
`timescale 1ns/100ps
`default_nettype none

module jsp_top
  import jsp_pkg::*;
#(
  parameter int unsigned fifo_depth   = 8,    // Entries per FIFO
  parameter bit          start_bit_en = 1'b1  // Input waits for a start bit
) (
  input  logic      tck_i,
  input  logic      rst_i,
  // TAP side
  input  logic      module_select_i,
  input  logic      capture_dr_i,
  input  logic      shift_dr_i,
  input  logic      update_dr_i,
  input  logic      tdi_i,
  output logic      tdo_o,
  // Host receive path
  output logic      rx_valid_o,
  output jsp_byte_t rx_data_o,
  input  logic      rx_ready_i,
  // Host transmit path
  input  logic      tx_valid_i,
  input  jsp_byte_t tx_data_i,
  output logic      tx_ready_o
);

  logic      rx_push;
  jsp_byte_t rx_push_data;
  jsp_cnt_t  rx_space;
  logic      tx_pop;
  jsp_byte_t tx_head;
  jsp_cnt_t  tx_fill;

  ////////////////////////////////////////////////////////////////////////////
  // Controllers

  jsp_in_ctrl #(
    .start_bit_en(start_bit_en)
  ) in_ctrl (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .module_select_i(module_select_i),
    .capture_dr_i   (capture_dr_i),
    .shift_dr_i     (shift_dr_i),
    .update_dr_i    (update_dr_i),
    .tdi_i          (tdi_i),
    .space_i        (rx_space),
    .push_o         (rx_push),
    .push_data_o    (rx_push_data)
  );

  jsp_out_ctrl out_ctrl (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .module_select_i(module_select_i),
    .capture_dr_i   (capture_dr_i),
    .shift_dr_i     (shift_dr_i),
    .update_dr_i    (update_dr_i),
    .tx_head_i      (tx_head),
    .tx_fill_i      (tx_fill),
    .rx_space_i     (rx_space),
    .tdo_o          (tdo_o),
    .pop_o          (tx_pop)
  );

  ////////////////////////////////////////////////////////////////////////////
  // FIFOs

  // JTAG pushes, host pops
  jsp_byte_fifo #(
    .fifo_depth(fifo_depth)
  ) rx_fifo (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .push_i     (rx_push),
    .push_data_i(rx_push_data),
    .pop_i      (1'b0),
    .out_ready_i(rx_ready_i),
    .in_valid_i (1'b0),
    .in_data_i  ('0),
    .head_o     (rx_data_o),
    .out_valid_o(rx_valid_o),
    .in_ready_o (),
    .fill_o     (),
    .space_o    (rx_space)
  );

  // Host pushes, JTAG pops
  jsp_byte_fifo #(
    .fifo_depth(fifo_depth)
  ) tx_fifo (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .push_i     (1'b0),
    .push_data_i('0),
    .pop_i      (tx_pop),
    .out_ready_i(1'b0),
    .in_valid_i (tx_valid_i),
    .in_data_i  (tx_data_i),
    .head_o     (tx_head),
    .out_valid_o(),
    .in_ready_o (tx_ready_o),
    .fill_o     (tx_fill),
    .space_o    ()
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the JTAG serial port testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module jsp_tb -f verilog.f
./obj_dir/Vjsp_tb > sim.log 2>&1 || true
cat sim.log

if grep -qxF "=== PASS ===" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== verif/jsp_checker.sv ====
// Concurrent assertions on byte FIFO strobes and counts bound into each FIFO
`timescale 1ns/100ps
`default_nettype none

module jsp_checker
  import jsp_pkg::*;
#(
  parameter int unsigned fifo_depth = 8
) (
  input  logic     tck_i,
  input  logic     rst_i,
  input  logic     push_i,
  input  logic     pop_i,
  input  logic     out_valid_o,
  input  logic     in_ready_o,
  input  jsp_cnt_t fill_o,
  input  jsp_cnt_t space_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Strobe side

  no_push_full: assert property (@(posedge tck_i) disable iff (rst_i) push_i |-> in_ready_o)
    else $error("Push strobe into a full FIFO");

  no_pop_empty: assert property (@(posedge tck_i) disable iff (rst_i) pop_i |-> out_valid_o)
    else $error("Pop strobe on an empty FIFO");

  ////////////////////////////////////////////////////////////////////////////
  // Counts are exact only below the saturation point

  generate
    if (fifo_depth <= 15) begin : g_count_sum
      count_sum: assert property (@(posedge tck_i) disable iff (rst_i)
        (5'(fill_o) + 5'(space_o)) == 5'(fifo_depth))
        else $error("Fill plus space differs from the FIFO depth");
    end
  endgenerate

endmodule

bind jsp_byte_fifo jsp_checker #(
  .fifo_depth(fifo_depth)
) fifo_chk (
  .tck_i      (tck_i),
  .rst_i      (rst_i),
  .push_i     (push_i),
  .pop_i      (pop_i),
  .out_valid_o(out_valid_o),
  .in_ready_o (in_ready_o),
  .fill_o     (fill_o),
  .space_o    (space_o)
);

`default_nettype wire

// ==== verif/jsp_tb.sv ====
// Clock, reset, frame tasks, frame table and scoreboard of the JTAG serial port testbench
`timescale 1ns/100ps
`default_nettype none

module jsp_tb
  import jsp_pkg::*;
();

  localparam int unsigned FIFO_DEPTH   = 8;
  localparam bit          START_BIT_EN = 1'b1;
  localparam int          NUM_ROWS     = 9;
  localparam logic [31:0] SEED         = 32'd68845;

  ////////////////////////////////////////////////////////////////////////////
  // Frame table with one row per test
  // U, host tx bytes, lead zeros, pause, drain ready pattern, expected space, expected writes

  localparam int          TBL_USER  [NUM_ROWS] = '{0, 0, 5, 10, 5, 6, 2, 4, 7};
  localparam int          TBL_TXN   [NUM_ROWS] = '{0, 3, 0, 0, 0, 2, 1, 4, 8};
  localparam int          TBL_LEAD  [NUM_ROWS] = '{0, 2, 3, 1, 0, 4, 0, 2, 2};
  localparam bit          TBL_PAUSE [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 1, 1};
  localparam logic [7:0]  TBL_RDY   [NUM_ROWS] = '{8'hff, 8'hff, 8'hff, 8'ha5, 8'h00,
                                                   8'h00, 8'hff, 8'h3c, 8'hff};
  localparam int          TBL_SPACE [NUM_ROWS] = '{8, 8, 8, 8, 8, 3, 0, 8, 8};
  localparam int          TBL_WR    [NUM_ROWS] = '{0, 0, 5, 8, 5, 3, 0, 4, 7};  // min(U, space)

  logic      tck_i;
  logic      rst_i;
  logic      module_select_i;
  logic      capture_dr_i;
  logic      shift_dr_i;
  logic      update_dr_i;
  logic      tdi_i;
  logic      tdo_o;
  logic      rx_valid_o;
  jsp_byte_t rx_data_o;
  logic      rx_ready_i;
  logic      tx_valid_i;
  jsp_byte_t tx_data_i;
  logic      tx_ready_o;

  jsp_byte_t   rx_exp [$];   // Bytes owed to the host in arrival order
  jsp_byte_t   tx_exp [$];   // Bytes held in the transmit FIFO
  jsp_byte_t   tx_send [$];  // Host bytes not yet accepted
  logic [31:0] rng_state;
  logic [7:0]  rdy_now;      // Host ready pattern with one bit per cycle
  logic [2:0]  phase;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_passed;
  int          cycle_cnt;
  int          cycle_limit;
  int          row;
  int          err_mark;

  jsp_top #(
    .fifo_depth  (FIFO_DEPTH),
    .start_bit_en(START_BIT_EN)
  ) dut (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .module_select_i(module_select_i),
    .capture_dr_i   (capture_dr_i),
    .shift_dr_i     (shift_dr_i),
    .update_dr_i    (update_dr_i),
    .tdi_i          (tdi_i),
    .tdo_o          (tdo_o),
    .rx_valid_o     (rx_valid_o),
    .rx_data_o      (rx_data_o),
    .rx_ready_i     (rx_ready_i),
    .tx_valid_i     (tx_valid_i),
    .tx_data_i      (tx_data_i),
    .tx_ready_o     (tx_ready_o)
  );

  initial begin
    tck_i = 1'b0;
    forever #50 tck_i = ~tck_i;  // 100 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_rand(output jsp_byte_t b);
    rng_state = xorshift32(rng_state);
    b = rng_state[7:0];
  endtask

  // Longest possible run where pauses at most double a frame
  function automatic int timeout_cycles();
    int total;
    int r;
    int tdi_len;
    int tdo_len;
    total = 10;
    for (r = 0; r < NUM_ROWS; r++) begin
      tdi_len = TBL_LEAD[r] + 1 + 8 + 8 * TBL_USER[r];
      tdo_len = 8 + 8 * TBL_TXN[r];
      total += TBL_TXN[r] + 2 * (((tdi_len > tdo_len) ? tdi_len : tdo_len) + 8) + 4;
      total += 8 * FIFO_DEPTH + 2;  // Drain with a sparse ready pattern
    end
    return total + 100;
  endfunction

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %02h expected %02h", $time, name, got, exp);
    end
  endtask

  // Host receive monitor for the transfer on the coming rising edge
  task automatic watch_rx();
    if (rx_valid_o && rx_ready_i) begin
      checks++;
      assert (rx_exp.size() != 0) else begin
        errors++;
        $display("Host received byte %02h at %0t although none was due", rx_data_o, $time);
      end
      if (rx_exp.size() != 0) begin
        check_value("rx_data_o", rx_data_o, rx_exp.pop_front());
      end
    end
  endtask

  // TAP pins, host ready and host transmit on one falling edge
  task automatic drive_cycle(input logic cap, input logic shift, input logic upd, input logic tdi);
    @(negedge tck_i);
    capture_dr_i = cap;
    shift_dr_i   = shift;
    update_dr_i  = upd;
    tdi_i        = tdi;
    rx_ready_i   = rdy_now[phase];
    phase++;
    if (tx_send.size() > 0) begin
      tx_valid_i = 1'b1;
      tx_data_i  = tx_send[0];
      if (tx_ready_o) begin
        tx_exp.push_back(tx_send.pop_front());
      end
    end else begin
      tx_valid_i = 1'b0;
      tx_data_i  = '0;
    end
    watch_rx();
  endtask

  task automatic send_host(input int n);
    jsp_byte_t b;
    int        i;
    for (i = 0; i < n; i++) begin
      next_rand(b);
      tx_send.push_back(b);
    end
    while (tx_send.size() > 0) begin
      drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    end
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    check_value("tx_ready_o", 8'(tx_ready_o), 8'(tx_exp.size() < FIFO_DEPTH));  // High unless full
  endtask

  // One full duplex frame with capture, shifts, optional pauses and update
  task automatic run_frame(input int r);
    logic      tdi_bits [$];
    logic      tdo_bits [$];
    jsp_byte_t wr_bytes [$];
    jsp_byte_t status;
    jsp_byte_t hdr;
    jsp_byte_t b;
    int        data_start;
    int        nbits;
    int        i;
    int        j;
    if (START_BIT_EN) begin
      for (i = 0; i < TBL_LEAD[r]; i++) begin
        tdi_bits.push_back(1'b0);     // Ignored before the start bit
      end
      tdi_bits.push_back(1'b1);
    end
    next_rand(hdr);                   // Reserved low nibble stays random
    hdr[7:4] = 4'(TBL_USER[r]);
    for (j = 0; j < 8; j++) begin
      tdi_bits.push_back(hdr[j]);
    end
    data_start = tdi_bits.size();
    for (i = 0; i < TBL_USER[r]; i++) begin
      next_rand(b);
      wr_bytes.push_back(b);
      for (j = 0; j < 8; j++) begin
        tdi_bits.push_back(b[j]);     // LSB first
      end
    end
    status = {4'(TBL_TXN[r]), 4'(TBL_SPACE[r])};  // Fill in the high nibble and space in the low
    for (j = 0; j < 8; j++) begin
      tdo_bits.push_back(status[j]);
    end
    for (i = 0; i < TBL_TXN[r]; i++) begin
      b = tx_exp.pop_front();
      for (j = 0; j < 8; j++) begin
        tdo_bits.push_back(b[j]);
      end
    end
    // One spare byte of zeros on both lines
    nbits = ((tdi_bits.size() > tdo_bits.size()) ? tdi_bits.size() : tdo_bits.size()) + 8;
    while (tdi_bits.size() < nbits) begin
      tdi_bits.push_back(1'b0);
    end
    while (tdo_bits.size() < nbits) begin
      tdo_bits.push_back(1'b0);
    end

    drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);  // Capture
    for (i = 0; i < nbits; i++) begin
      if (TBL_PAUSE[r] && (i % 11 == 5)) begin
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
      end
      drive_cycle(1'b0, 1'b1, 1'b0, tdi_bits[i]);
      check_value("tdo_o", 8'(tdo_o), 8'(tdo_bits[i]));
      // Eighth bit of a data byte is pushed on this edge while allowed
      if ((i >= data_start) && (((i - data_start) % 8) == 7)) begin
        if (((i - data_start) / 8) < TBL_WR[r]) begin
          rx_exp.push_back(wr_bytes[(i - data_start) / 8]);
        end
      end
    end
    drive_cycle(1'b0, 1'b0, 1'b1, 1'b0);  // Update
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic drain_rx(input logic [7:0] pattern);
    rdy_now = pattern;
    while (rx_exp.size() > 0) begin
      drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    end
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    check_value("rx_valid_o", 8'(rx_valid_o), 8'h00);
    rdy_now = '0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt <= cycle_limit) begin
      @(posedge tck_i);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    cycle_limit     = timeout_cycles();
    rst_i           = 1'b1;
    module_select_i = 1'b1;
    capture_dr_i    = 1'b0;
    shift_dr_i      = 1'b0;
    update_dr_i     = 1'b0;
    tdi_i           = 1'b0;
    rx_ready_i      = 1'b0;
    tx_valid_i      = 1'b0;
    tx_data_i       = '0;
    rdy_now         = '0;
    phase           = '0;
    rng_state       = SEED;
    errors          = 0;
    checks          = 0;
    tests_run       = 0;
    tests_passed    = 0;
    repeat (3) @(negedge tck_i);
    rst_i = 1'b0;

    // Idle outputs right after reset
    check_value("tdo_o", 8'(tdo_o), 8'h00);
    check_value("rx_valid_o", 8'(rx_valid_o), 8'h00);
    check_value("tx_ready_o", 8'(tx_ready_o), 8'h01);
    check_value("rx_push", 8'(dut.rx_push), 8'h00);
    check_value("tx_pop", 8'(dut.tx_pop), 8'h00);
    tests_run++;
    if (errors == 0) begin
      tests_passed++;
      $display("test reset: ok");
    end else begin
      $display("test reset: failed with %0d errors", errors);
    end

    for (row = 0; row < NUM_ROWS; row++) begin
      err_mark = errors;
      rdy_now  = '0;         // Host holds receive bytes during the frame
      send_host(TBL_TXN[row]);
      run_frame(row);
      if (TBL_RDY[row] != '0) begin
        drain_rx(TBL_RDY[row]);
      end
      tests_run++;
      if (errors == err_mark) begin
        tests_passed++;
        $display("test %0d U=%0d tx=%0d wr=%0d: ok", row, TBL_USER[row], TBL_TXN[row],
                 TBL_WR[row]);
      end else begin
        $display("test %0d U=%0d tx=%0d wr=%0d: failed with %0d errors", row, TBL_USER[row],
                 TBL_TXN[row], TBL_WR[row], errors - err_mark);
      end
    end

    $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d", tests_run,
             tests_passed, tests_run - tests_passed, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/jsp_pkg.sv
rtl/jsp_byte_fifo.sv
rtl/jsp_in_ctrl.sv
rtl/jsp_out_ctrl.sv
rtl/jsp_top.sv
verif/jsp_checker.sv
verif/jsp_tb.sv
